/* vlog.f */
eeprom_pkg.sv
credit_queue.sv
eeprom_cmd_decode.sv
twi_execute.sv
eeprom_result.sv
eeprom_ctrl_top.sv
eeprom_slave_model.sv
eeprom_ctrl_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module eeprom_ctrl_tb -f vlog.f -o eeprom_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/eeprom_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

/* eeprom_ctrl_tb.sv */
`timescale 1ns/10ps

module eeprom_ctrl_tb;
    import eeprom_pkg::*;

    localparam int NUM_CMDS   = 40;
    localparam int MAX_CYCLES = NUM_CMDS * 200;

    logic CLK;
    logic RESET;
    logic cmd_valid;
    cmd_t cmd;
    logic cmd_credit;
    logic rsp_valid;
    rsp_t rsp;
    logic rsp_credit;
    logic scl;
    logic sda_drive_low;
    logic sda_in;
    logic frame_err;

    logic [7:0] ref_mem [1024];
    rsp_t       exp_mem [64];  // expected responses in command order
    rsp_t       exp_now;
    int         issued;
    int         exp_rd;
    int         in_queue;   // commands held in the DUT
    int         granted;    // response credits the DUT holds
    int         cycles = 0;
    int         errors = 0;

    eeprom_ctrl_top eeprom_ctrl_top_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_credit    (cmd_credit),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_credit    (rsp_credit),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    eeprom_slave_model slave_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in),
        .frame_err     (frame_err)
    );

    assign exp_now = exp_mem[exp_rd[5:0]];

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // directed opening, then random traffic
    function automatic cmd_t next_command(int n);
        cmd_t        c;
        logic [31:0] r;
        r       = $urandom;
        c.op    = r[0] ? op_read : op_write;
        c.addr  = {r[3] & r[4], r[2:1], 4'h3, r[8:5]};
        c.wdata = r[23:16];
        case (n)
            0: c = '{op: op_write, addr: 11'h0A7, wdata: 8'hC3};
            1: c = '{op: op_read,  addr: 11'h0A7, wdata: 8'h00};
            2: c = '{op: op_read,  addr: 11'h316, wdata: 8'h00};  // never written
            3: c = '{op: op_write, addr: 11'h4A7, wdata: 8'h3C};  // aliases 0A7 if block ignored
            4: c = '{op: op_read,  addr: 11'h4A7, wdata: 8'h00};
            5: c = '{op: op_read,  addr: 11'h0A7, wdata: 8'h00};
            default: ;
        endcase
        return c;
    endfunction

    task automatic record_expected(cmd_t c);
        rsp_t e;
        e = '0;
        if (c.addr[10])
            e.nack = 1'b1;  // no device in blocks 4 to 7
        else if (c.op == op_write)
            ref_mem[c.addr[9:0]] = c.wdata;
        else
            e.rdata = ref_mem[c.addr[9:0]];
        exp_mem[issued[5:0]] = e;
    endtask

    initial
    begin
        int   credits;
        int   pending;
        int   free_wait;
        int   rsp_seen;
        cmd_t c;
        void'($urandom(64944));
        for (int i = 0; i < 1024; i++)
            ref_mem[i[9:0]] = 8'(i) ^ 8'h5A;
        cmd_valid  = 1'b0;
        cmd        = '0;
        rsp_credit = 1'b0;
        RESET      = 1'b1;
        credits    = CMD_DEPTH;
        pending    = 0;
        free_wait  = 0;
        rsp_seen   = 0;
        issued     = 0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        while (rsp_seen < NUM_CMDS)
        begin
            @(negedge CLK);
            cmd_valid  = 1'b0;
            rsp_credit = 1'b0;
            if (cmd_credit)
                credits++;
            if (rsp_valid)
            begin
                rsp_seen++;
                pending++;  // host keeps it in a buffer slot for a while
            end
            if (pending > 0 && free_wait == 0)
            begin
                rsp_credit = 1'b1;
                pending--;
                free_wait  = $urandom % 256;
            end
            else if (free_wait > 0)
                free_wait--;
            if (issued < NUM_CMDS && credits > 0 && ($urandom % 3) == 0)
            begin
                c = next_command(issued);
                record_expected(c);
                cmd       = c;
                cmd_valid = 1'b1;
                credits--;
                issued++;
            end
        end
        @(negedge CLK);
        cmd_valid  = 1'b0;
        rsp_credit = 1'b0;
        repeat (20) @(negedge CLK);  // catch stray responses
        $display("errors: %0d  commands: %0d  responses: %0d", errors, issued, rsp_seen);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            exp_rd   <= 0;
            in_queue <= 0;
            granted  <= HOST_RSP_CREDITS;
        end
        else
        begin
            if (rsp_valid)
                exp_rd <= exp_rd + 1;
            in_queue <= in_queue + (cmd_valid ? 1 : 0) - (cmd_credit ? 1 : 0);
            granted  <= granted - (rsp_valid ? 1 : 0) + (rsp_credit ? 1 : 0);
        end
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES)
        begin
            $display("timeout after %0d cycles with %0d errors", cycles, errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    a_rsp_value: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |-> (rsp == exp_now))
        else
        begin
            errors++;
            $display("Error: rsp = %h, expected %h", $sampled(rsp), $sampled(exp_now));
        end

    a_rsp_expected: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |-> (exp_rd < issued))
        else
        begin
            errors++;
            $display("a response arrived with no command outstanding");
        end

    a_rsp_credit: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |-> (granted > 0))
        else
        begin
            errors++;
            $display("a response was sent while the host had granted no credit");
        end

    // a spare credit would let the host overrun the command queue
    a_cmd_credit: assert property (@(posedge CLK) disable iff (RESET)
        cmd_credit |-> (in_queue > 0))
        else
        begin
            errors++;
            $display("a command credit came back with no command queued");
        end

    a_framing: assert property (@(posedge CLK) disable iff (RESET) !frame_err)
        else
        begin
            errors++;
            $display("the EEPROM model saw a start or stop inside a byte");
        end

    a_reset_state: assert property (@(posedge CLK)
        (!RESET && $past(RESET)) |-> (scl && !sda_drive_low && !cmd_credit && !rsp_valid))
        else
        begin
            errors++;
            $display("bus or handshake outputs not idle after reset");
        end

endmodule

/* eeprom_slave_model.sv */
`timescale 1ns/10ps

module eeprom_slave_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda_drive_low,
    output logic sda_in,
    output logic frame_err
);
    logic [7:0] mem [1024];  // 8-kbit part, blocks 0 to 3
    logic       drive_low;
    logic       scl_q;
    logic       sda_q;
    logic       active;
    logic       sending;
    logic       acked;
    logic       rd_req;
    logic [3:0] cnt;      // scl rises within the current byte
    logic [1:0] byte_no;
    logic [7:0] sr;
    logic [7:0] tx;
    logic [9:0] ptr;
    logic       start_seen;
    logic       stop_seen;
    logic       dev_ok;

    assign sda_in     = !(sda_drive_low || drive_low);  // wired-AND
    assign start_seen = scl && scl_q && sda_q && !sda_in;
    assign stop_seen  = scl && scl_q && !sda_q && sda_in;
    assign dev_ok     = (sr[7:4] == 4'b1010) && !sr[3];

    initial
    begin
        for (int i = 0; i < 1024; i++)
            mem[i[9:0]] = 8'(i) ^ 8'h5A;
    end

    always @(posedge CLK)
    begin
        scl_q     <= scl;
        sda_q     <= sda_in;
        frame_err <= 1'b0;
        if (RESET)
        begin
            drive_low <= 1'b0;
            active    <= 1'b0;
            sending   <= 1'b0;
            acked     <= 1'b0;
            rd_req    <= 1'b0;
            cnt       <= '0;
            byte_no   <= '0;
        end
        else if (start_seen || stop_seen)
        begin
            // one scl rise before a restart or stop is normal
            frame_err <= active && (cnt > 4'd1);
            active    <= start_seen;
            sending   <= 1'b0;
            drive_low <= 1'b0;
            cnt       <= '0;
            byte_no   <= '0;
        end
        else if (active && scl && !scl_q)
        begin
            if (cnt < 4'd8 && !sending)
                sr <= {sr[6:0], sda_in};
            cnt <= cnt + 4'd1;
        end
        else if (active && !scl && scl_q)
        begin
            if (cnt == 4'd8 && !sending)
            begin
                acked     <= (byte_no == 2'd0) ? dev_ok : (byte_no != 2'd3);
                drive_low <= (byte_no == 2'd0) ? dev_ok : (byte_no != 2'd3);
                if (byte_no == 2'd0)
                begin
                    rd_req   <= sr[0];
                    ptr[9:8] <= sr[2:1];
                end
                else if (byte_no == 2'd1)
                    ptr[7:0] <= sr;
                else if (byte_no == 2'd2)
                    mem[ptr] <= sr;
            end
            else if (cnt == 4'd8)
                drive_low <= 1'b0;  // master ack slot
            else if (cnt == 4'd9)
            begin
                cnt       <= '0;
                byte_no   <= byte_no + 2'd1;
                drive_low <= 1'b0;
                if (!acked || sending)
                    active <= 1'b0;
                else if (rd_req)
                begin
                    sending   <= 1'b1;
                    tx        <= mem[ptr];
                    drive_low <= !mem[ptr][7];
                end
            end
            else if (sending && cnt != 4'd0)
            begin
                tx        <= {tx[6:0], 1'b0};
                drive_low <= !tx[6];
            end
        end
    end

endmodule

/* eeprom_ctrl_top.sv */
`timescale 1ns/10ps

module eeprom_ctrl_top (
    input  logic             CLK,
    input  logic             RESET,
    input  logic             cmd_valid,
    input  eeprom_pkg::cmd_t cmd,
    output logic             cmd_credit,
    output logic             rsp_valid,
    output eeprom_pkg::rsp_t rsp,
    input  logic             rsp_credit,
    output logic             scl,
    output logic             sda_drive_low,
    input  logic             sda_in
);
    import eeprom_pkg::*;

    logic job_valid;
    logic job_ready;
    job_t job;
    logic rsp_room;
    logic done;
    rsp_t rsp_out;

    eeprom_cmd_decode decode_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .rsp_room   (rsp_room),
        .job_ready  (job_ready),
        .job_valid  (job_valid),
        .job        (job)
    );

    twi_execute execute_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .job_valid     (job_valid),
        .job           (job),
        .job_ready     (job_ready),
        .done          (done),
        .rsp_out       (rsp_out),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    eeprom_result result_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .done       (done),
        .rsp_out    (rsp_out),
        .rsp_room   (rsp_room),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

endmodule

/* eeprom_result.sv */
`timescale 1ns/10ps

module eeprom_result (
    input  logic             CLK,
    input  logic             RESET,
    input  logic             done,
    input  eeprom_pkg::rsp_t rsp_out,
    output logic             rsp_room,
    output logic             rsp_valid,
    output eeprom_pkg::rsp_t rsp,
    input  logic             rsp_credit
);
    import eeprom_pkg::*;

    localparam int CW = $clog2(HOST_RSP_CREDITS + 1);

    logic [CW-1:0] credits;  // host buffer slots we may fill
    logic          q_not_empty;

    credit_queue #(
        .payload_t (rsp_t),
        .DEPTH     (RSP_DEPTH)
    ) rsp_q_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (done),
        .push_data (rsp_out),
        .pop       (rsp_valid),
        .pop_data  (rsp),
        .not_empty (q_not_empty),
        .not_full  (rsp_room)
    );

    assign rsp_valid = q_not_empty && (credits != '0);

    always_ff @(posedge CLK)
    begin
        if (RESET)
            credits <= CW'(HOST_RSP_CREDITS);
        else if (rsp_valid && !rsp_credit)
            credits <= credits - 1'b1;
        else if (rsp_credit && !rsp_valid)
            credits <= credits + 1'b1;
    end

    // host returned more credits than it was given
    a_credit_bound: assert property (@(posedge CLK) disable iff (RESET)
        credits <= CW'(HOST_RSP_CREDITS))
        else $error("eeprom_result: host credit overflow");

endmodule

/* twi_execute.sv */
`timescale 1ns/10ps

module twi_execute (
    input  logic             CLK,
    input  logic             RESET,
    input  logic             job_valid,
    input  eeprom_pkg::job_t job,
    output logic             job_ready,
    output logic             done,
    output eeprom_pkg::rsp_t rsp_out,
    output logic             scl,
    output logic             sda_drive_low,
    input  logic             sda_in
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        ph_idle,
        ph_start,
        ph_byte,
        ph_ack,
        ph_restart,
        ph_rdbyte,
        ph_mnack,
        ph_stop
    } phase_e;

    localparam int TW = (QUARTER > 1) ? $clog2(QUARTER) : 1;

    phase_e        phase;
    logic [TW-1:0] tick;
    logic [1:0]    q;         // quarter within the bit
    logic [2:0]    bit_cnt;
    logic [1:0]    byte_idx;  // 0 ctrl, 1 addr, 2 wdata, 3 read ctrl
    logic          nack;
    logic [7:0]    shift;
    job_t          job_q;
    logic          accept;
    logic          step;
    logic          sample;
    logic          bit_end;
    logic          mid;

    assign accept  = job_valid && job_ready;
    assign step    = (tick == TW'(QUARTER - 1));
    assign sample  = step && (q == 2'd2);
    assign bit_end = step && (q == 2'd3);
    assign mid     = (q == 2'd1) || (q == 2'd2);  // scl high in the middle quarters

    // hold off one cycle after done so the response count is settled
    assign job_ready = (phase == ph_idle) && !done;

    always_comb
    begin
        scl           = 1'b1;
        sda_drive_low = 1'b0;
        case (phase)
            ph_start:
            begin
                scl           = (q != 2'd3);
                sda_drive_low = q[1];  // falls while scl high
            end
            ph_restart:
            begin
                scl           = mid;
                sda_drive_low = q[1];
            end
            ph_byte:
            begin
                scl           = mid;
                sda_drive_low = !shift[7];
            end
            ph_ack, ph_rdbyte, ph_mnack:
                scl = mid;  // line released
            ph_stop:
            begin
                scl           = (q != 2'd0);
                sda_drive_low = !q[1];  // rises while scl high
            end
            default:
                scl = 1'b1;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase    <= ph_idle;
            tick     <= '0;
            q        <= '0;
            bit_cnt  <= '0;
            byte_idx <= '0;
            nack     <= 1'b0;
            shift    <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (phase == ph_idle)
            begin
                tick <= '0;
                q    <= '0;
                if (accept)
                begin
                    phase    <= ph_start;
                    byte_idx <= 2'd0;
                    nack     <= 1'b0;
                end
            end
            else
            begin
                tick <= step ? '0 : tick + 1'b1;
                if (step)
                    q <= q + 1'b1;
                if (sample && phase == ph_ack && sda_in)
                    nack <= 1'b1;
                if (sample && phase == ph_rdbyte)
                    shift <= {shift[6:0], sda_in};
                if (bit_end)
                begin
                    case (phase)
                        ph_start:
                        begin
                            phase   <= ph_byte;
                            bit_cnt <= 3'd7;
                            shift   <= job_q.ctrl_byte;
                        end
                        ph_restart:
                        begin
                            phase   <= ph_byte;
                            bit_cnt <= 3'd7;
                            shift   <= job_q.ctrl_byte | 8'h01;  // read direction
                        end
                        ph_byte:
                        begin
                            shift <= {shift[6:0], 1'b0};
                            if (bit_cnt == 3'd0)
                                phase <= ph_ack;
                            else
                                bit_cnt <= bit_cnt - 1'b1;
                        end
                        ph_ack:
                        begin
                            bit_cnt <= 3'd7;
                            if (nack)
                                phase <= ph_stop;
                            else if (byte_idx == 2'd0)
                            begin
                                phase    <= ph_byte;
                                byte_idx <= 2'd1;
                                shift    <= job_q.addr_low;
                            end
                            else if (byte_idx == 2'd1 && job_q.is_read)
                            begin
                                phase    <= ph_restart;
                                byte_idx <= 2'd3;
                            end
                            else if (byte_idx == 2'd1)
                            begin
                                phase    <= ph_byte;
                                byte_idx <= 2'd2;
                                shift    <= job_q.wdata;
                            end
                            else if (byte_idx == 2'd2)
                                phase <= ph_stop;
                            else
                                phase <= ph_rdbyte;
                        end
                        ph_rdbyte:
                        begin
                            if (bit_cnt == 3'd0)
                                phase <= ph_mnack;
                            else
                                bit_cnt <= bit_cnt - 1'b1;
                        end
                        ph_mnack:
                            phase <= ph_stop;
                        default:
                        begin
                            phase <= ph_idle;
                            done  <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
            job_q <= job;
        if (phase == ph_stop && bit_end)
        begin
            rsp_out.nack  <= nack;
            rsp_out.rdata <= (job_q.is_read && !nack) ? shift : 8'h00;
        end
    end

    // data moves only with scl low, except for start, restart and stop
    a_sda_framing: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !(phase inside {ph_start, ph_restart, ph_stop}))
            |-> $stable(sda_drive_low))
        else $error("twi_execute: sda moved while scl high");

endmodule

/* eeprom_cmd_decode.sv */
`timescale 1ns/10ps

module eeprom_cmd_decode (
    input  logic             CLK,
    input  logic             RESET,
    input  logic             cmd_valid,
    input  eeprom_pkg::cmd_t cmd,
    output logic             cmd_credit,
    input  logic             rsp_room,
    input  logic             job_ready,
    output logic             job_valid,
    output eeprom_pkg::job_t job
);
    import eeprom_pkg::*;

    cmd_t head;
    logic q_not_empty;
    logic q_not_full;
    logic pop;

    credit_queue #(
        .payload_t (cmd_t),
        .DEPTH     (CMD_DEPTH)
    ) cmd_q_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (cmd_valid),
        .push_data (cmd),
        .pop       (pop),
        .pop_data  (head),
        .not_empty (q_not_empty),
        .not_full  (q_not_full)
    );

    // one job at a time, and only with room left for its response
    assign pop = q_not_empty && rsp_room && job_ready && !job_valid;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            job_valid  <= 1'b0;
            cmd_credit <= 1'b0;
        end
        else
        begin
            cmd_credit <= pop;  // slot freed, hand credit back
            if (pop)
                job_valid <= 1'b1;
            else if (job_ready)
                job_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (pop)
        begin
            job.is_read   <= (head.op == op_read);
            job.ctrl_byte <= {DEVICE_CODE, head.addr[10:8], 1'b0};
            job.addr_low  <= head.addr[7:0];
            job.wdata     <= head.wdata;
        end
    end

    // host sent without holding a credit
    a_host_credit: assert property (@(posedge CLK) disable iff (RESET) cmd_valid |-> q_not_full)
        else $error("eeprom_cmd_decode: command without credit");

endmodule

/* credit_queue.sv */
`timescale 1ns/10ps

module credit_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     not_full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;

    assign pop_data  = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign not_full  = (count != (PTR_W + 1)'(DEPTH));

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    a_no_overflow: assert property (@(posedge CLK) disable iff (RESET) push |-> not_full)
        else $error("credit_queue: push while full");
    a_no_underflow: assert property (@(posedge CLK) disable iff (RESET) pop |-> not_empty)
        else $error("credit_queue: pop while empty");

endmodule

/* eeprom_pkg.sv */
package eeprom_pkg;

    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } eeprom_op_e;

    // one host command
    typedef struct packed {
        eeprom_op_e  op;
        logic [10:0] addr;
        logic [7:0]  wdata;
    } cmd_t;

    // decoded work for the bus engine
    typedef struct packed {
        logic        is_read;
        logic [7:0]  ctrl_byte;  // 1010, block bits, write dir
        logic [7:0]  addr_low;
        logic [7:0]  wdata;
    } job_t;

    typedef struct packed {
        logic        nack;
        logic [7:0]  rdata;
    } rsp_t;

    localparam int CMD_DEPTH        = 2;  // also the host's starting credits
    localparam int HOST_RSP_CREDITS = 2;
    localparam int RSP_DEPTH        = 2;
    localparam int QUARTER          = 1;  // CLK cycles per quarter SCL period

    localparam logic [3:0] DEVICE_CODE = 4'b1010;

endpackage
